//--- csr_unit_top.f
+incdir+hw
hw/csr_pkg.sv
hw/csr_cmd_fsm.sv
hw/us_timer.sv
hw/csr_counter64.sv
hw/csr_regs.sv
hw/csr_unit_top.sv
verif/csr_unit_tb.sv

//--- hw/csr_cmd_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_consts.svh"

module csr_cmd_fsm import csr_pkg::*; (
    input  logic clk,
    input  logic rst,
    // command port
    input  logic cmd_req_i,
    output logic cmd_ack_o,
    // to register block
    output logic exec_o,
    input  logic host_send_i,
    // host port
    output logic host_req_o,
    input  logic host_ack_i
);

cmd_state_t state;
cmd_state_t state_nxt;

// ----------------------------------------------------------
// state register
// ----------------------------------------------------------
always_ff @(posedge clk) begin
    if (rst) begin
        state <= IDLE;
    end else begin
        state <= state_nxt;
    end
end

// ----------------------------------------------------------
// next state
// ----------------------------------------------------------
always_comb begin
    state_nxt = state;
    case (state)
        IDLE: begin
            if (cmd_req_i) state_nxt = EXEC;
        end
        EXEC: begin
            // tohost writes go out to the host before the ack
            state_nxt = host_send_i ? HOST_REQ : ACK;
        end
        HOST_REQ: begin
            if (host_ack_i) state_nxt = HOST_REL;
        end
        HOST_REL: begin
            if (!host_ack_i) state_nxt = ACK;
        end
        ACK: begin
            if (!cmd_req_i) state_nxt = IDLE;
        end
        default: begin
            state_nxt = IDLE;
        end
    endcase
end

// outputs decoded from state only
assign exec_o = (state == EXEC);
assign host_req_o = (state == HOST_REQ);
assign cmd_ack_o = (state == ACK);

// ----------------------------------------------------------
// handshake checks
// ----------------------------------------------------------

// host must have released ack from the last transfer
a_host_req_rise: assert property (
    @(posedge clk) disable iff (rst)
    $rose(host_req_o) |-> !host_ack_i
) else $error("host_req_o raised while host_ack_i still high");

// master may only drop req once ack is already up
a_cmd_req_hold: assert property (
    @(posedge clk) disable iff (rst)
    (cmd_ack_o && !cmd_req_i) |-> ($past(state) == ACK)
) else $error("cmd_req_i dropped before cmd_ack_o was seen");

endmodule

`default_nettype wire

//--- hw/csr_consts.svh
`ifndef CSR_CONSTS_SVH
`define CSR_CONSTS_SVH

// ----------------------------------------------------------
// widths
// ----------------------------------------------------------

// one csr word
`define CSR_ARCH_WIDTH 32

// full counter, two csr words
`define CSR_CNT_WIDTH 64

// csr address field
`define CSR_ADDR_WIDTH 12

// ----------------------------------------------------------
// clocking
// ----------------------------------------------------------
`define CSR_CLOCK_FREQ_HZ 100_000_000

// hz per 1 MHz, divisor base for the us tick
`define CSR_HZ_PER_US 1_000_000

`endif

//--- hw/csr_counter64.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_consts.svh"

module csr_counter64 import csr_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      inc_i,
    input  logic      wr_lo_i,
    input  logic      wr_hi_i,
    input  csr_word_t wdata_i,
    output csr_cnt_t  count_o
);

localparam int unsigned LO_W = `CSR_ARCH_WIDTH;
localparam int unsigned CNT_W = `CSR_CNT_WIDTH;

// ----------------------------------------------------------
// counter with writable halves
// ----------------------------------------------------------

// a write replaces one half and skips the increment
always_ff @(posedge clk) begin
    if (rst) begin
        count_o <= '0;
    end else if (wr_lo_i) begin
        count_o[LO_W-1:0] <= wdata_i;
    end else if (wr_hi_i) begin
        count_o[CNT_W-1:LO_W] <= wdata_i;
    end else begin
        count_o <= count_o + csr_cnt_t'(inc_i);
    end
end

// ----------------------------------------------------------
// checks
// ----------------------------------------------------------

// decoder drives at most one half per command
a_one_half: assert property (
    @(posedge clk) disable iff (rst)
    !(wr_lo_i && wr_hi_i)
) else $error("both counter halves written in the same cycle");

// write strobes come from a single exec cycle
a_wr_pulse: assert property (
    @(posedge clk) disable iff (rst)
    (wr_lo_i || wr_hi_i) |=> !(wr_lo_i || wr_hi_i)
) else $error("counter write held longer than one cycle");

endmodule

`default_nettype wire

//--- hw/csr_pkg.sv
`default_nettype none

`include "csr_consts.svh"

package csr_pkg;

    // data words
    typedef logic [`CSR_ARCH_WIDTH-1:0] csr_word_t;
    typedef logic [`CSR_CNT_WIDTH-1:0] csr_cnt_t;

    // supported machine-mode csr addresses
    typedef enum logic [`CSR_ADDR_WIDTH-1:0] {
        CSR_MSCRATCH  = 12'h340,
        CSR_TOHOST    = 12'h51E,
        CSR_MCYCLE    = 12'hB00,
        CSR_MINSTRET  = 12'hB02,
        CSR_MCYCLEH   = 12'hB80,
        CSR_MINSTRETH = 12'hB82,
        CSR_TIME      = 12'hC01,
        CSR_TIMEH     = 12'hC81
    } csr_addr_t;

    // same encoding as funct3[1:0] of csrrw/csrrs/csrrc
    typedef enum logic [1:0] {
        CSR_OP_RW = 2'd1,
        CSR_OP_RS = 2'd2,
        CSR_OP_RC = 2'd3
    } csr_op_t;

    // command sequencer states
    typedef enum logic [2:0] {
        IDLE     = 3'd0,
        EXEC     = 3'd1,
        HOST_REQ = 3'd2,
        HOST_REL = 3'd3,
        ACK      = 3'd4
    } cmd_state_t;

endpackage

`default_nettype wire

//--- hw/csr_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_consts.svh"

module csr_regs import csr_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    // command from the sequencer
    input  logic      exec_i,
    input  csr_op_t   op_i,
    input  csr_addr_t addr_i,
    input  csr_word_t wdata_i,
    // events
    input  logic      ret_i,
    input  csr_cnt_t  mtime_i,
    // results
    output csr_word_t rdata_o,
    output logic      host_send_o,
    output csr_word_t tohost_o
);

localparam int unsigned LO_W = `CSR_ARCH_WIDTH;
localparam int unsigned CNT_W = `CSR_CNT_WIDTH;

csr_word_t mscratch;
csr_cnt_t mcycle;
csr_cnt_t minstret;
csr_word_t csr_old;
csr_word_t csr_new;

// ----------------------------------------------------------
// read mux
// ----------------------------------------------------------
always_comb begin
    csr_old = '0;
    case (addr_i)
        CSR_TOHOST:    csr_old = tohost_o;
        CSR_MSCRATCH:  csr_old = mscratch;
        CSR_MCYCLE:    csr_old = mcycle[LO_W-1:0];
        CSR_MCYCLEH:   csr_old = mcycle[CNT_W-1:LO_W];
        CSR_MINSTRET:  csr_old = minstret[LO_W-1:0];
        CSR_MINSTRETH: csr_old = minstret[CNT_W-1:LO_W];
        CSR_TIME:      csr_old = mtime_i[LO_W-1:0];
        CSR_TIMEH:     csr_old = mtime_i[CNT_W-1:LO_W];
        // unmapped reads as zero
        default:       csr_old = '0;
    endcase
end

// read-modify-write value
always_comb begin
    csr_new = csr_old;
    case (op_i)
        CSR_OP_RW: csr_new = wdata_i;
        CSR_OP_RS: csr_new = csr_old | wdata_i;
        CSR_OP_RC: csr_new = csr_old & ~wdata_i;
        default:   csr_new = csr_old;
    endcase
end

// ----------------------------------------------------------
// plain registers
// ----------------------------------------------------------
always_ff @(posedge clk) begin
    if (rst) begin
        tohost_o <= '0;
        mscratch <= '0;
    end else if (exec_i) begin
        case (addr_i)
            CSR_TOHOST:   tohost_o <= csr_new;
            CSR_MSCRATCH: mscratch <= csr_new;
            default: ;
        endcase
    end
end

// old value, held until the next command
always_ff @(posedge clk) begin
    if (exec_i) rdata_o <= csr_old;
end

// any op on tohost counts as a write
assign host_send_o = exec_i && (addr_i == CSR_TOHOST);

// ----------------------------------------------------------
// counters
// ----------------------------------------------------------
csr_counter64 mcycle_cnt (
    .clk     (clk),
    .rst     (rst),
    .inc_i   (1'b1),
    .wr_lo_i (exec_i && (addr_i == CSR_MCYCLE)),
    .wr_hi_i (exec_i && (addr_i == CSR_MCYCLEH)),
    .wdata_i (csr_new),
    .count_o (mcycle)
);

csr_counter64 minstret_cnt (
    .clk     (clk),
    .rst     (rst),
    .inc_i   (ret_i),
    .wr_lo_i (exec_i && (addr_i == CSR_MINSTRET)),
    .wr_hi_i (exec_i && (addr_i == CSR_MINSTRETH)),
    .wdata_i (csr_new),
    .count_o (minstret)
);

endmodule

`default_nettype wire

//--- hw/csr_unit_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_consts.svh"

module csr_unit_top import csr_pkg::*; #(
    parameter int unsigned CLOCK_FREQ_HZ = `CSR_CLOCK_FREQ_HZ
)(
    input  logic      clk,
    input  logic      rst,
    // command port
    input  logic      cmd_req_i,
    input  csr_op_t   cmd_op_i,
    input  csr_addr_t cmd_addr_i,
    input  csr_word_t cmd_wdata_i,
    output logic      cmd_ack_o,
    output csr_word_t cmd_rdata_o,
    // retirement pulse
    input  logic      ret_i,
    // host port
    output logic      host_req_o,
    output csr_word_t host_data_o,
    input  logic      host_ack_i
);

logic exec;
logic host_send;
csr_cnt_t mtime;

csr_cmd_fsm csr_cmd_fsm_i (
    .clk         (clk),
    .rst         (rst),
    .cmd_req_i   (cmd_req_i),
    .cmd_ack_o   (cmd_ack_o),
    .exec_o      (exec),
    .host_send_i (host_send),
    .host_req_o  (host_req_o),
    .host_ack_i  (host_ack_i)
);

us_timer #(
    .CLOCK_FREQ_HZ (CLOCK_FREQ_HZ)
) us_timer_i (
    .clk     (clk),
    .rst     (rst),
    .mtime_o (mtime)
);

// tohost register doubles as the host data bus
csr_regs csr_regs_i (
    .clk         (clk),
    .rst         (rst),
    .exec_i      (exec),
    .op_i        (cmd_op_i),
    .addr_i      (cmd_addr_i),
    .wdata_i     (cmd_wdata_i),
    .ret_i       (ret_i),
    .mtime_i     (mtime),
    .rdata_o     (cmd_rdata_o),
    .host_send_o (host_send),
    .tohost_o    (host_data_o)
);

endmodule

`default_nettype wire

//--- hw/us_timer.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_consts.svh"

module us_timer import csr_pkg::*; #(
    parameter int unsigned CLOCK_FREQ_HZ = `CSR_CLOCK_FREQ_HZ
)(
    input  logic     clk,
    input  logic     rst,
    output csr_cnt_t mtime_o
);

localparam int unsigned CLOCKS_PER_US = CLOCK_FREQ_HZ / `CSR_HZ_PER_US;
// keep one bit when the divisor is 1
localparam int unsigned DIV_W = (CLOCKS_PER_US > 1) ? $clog2(CLOCKS_PER_US) : 1;
localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(CLOCKS_PER_US - 1);

logic [DIV_W-1:0] cnt_us;
logic tick_us;

// divide down to one tick per microsecond
always_ff @(posedge clk) begin
    if (rst) begin
        cnt_us <= '0;
        tick_us <= 1'b0;
    end else if (cnt_us == DIV_LAST) begin
        cnt_us <= '0;
        tick_us <= 1'b1;
    end else begin
        cnt_us <= cnt_us + 1'b1;
        tick_us <= 1'b0;
    end
end

// time follows the tick by one cycle
always_ff @(posedge clk) begin
    if (rst) mtime_o <= '0;
    else mtime_o <= mtime_o + csr_cnt_t'(tick_us);
end

if (CLOCKS_PER_US > 1) begin : gen_tick_chk
    a_tick_single: assert property (
        @(posedge clk) disable iff (rst) tick_us |=> !tick_us
    ) else $error("us tick high two cycles in a row");
end

endmodule

`default_nettype wire

//--- verif/csr_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module csr_unit_tb import csr_pkg::*; ();

localparam int unsigned N_RMW = 12;
localparam int unsigned N_HOST = 8;
localparam int unsigned RET_WINDOW = 64;
// rmw pairs, minstret, mcycle, time, tohost, unmapped
localparam int unsigned NUM_CMDS = 2 * N_RMW + 3 + 3 + 5 + N_HOST + 1 + 4;
localparam csr_addr_t UNMAPPED = csr_addr_t'(12'h123);

logic clk = 1'b0;
logic rst;
logic cmd_req;
csr_op_t cmd_op;
csr_addr_t cmd_addr;
csr_word_t cmd_wdata;
logic cmd_ack;
csr_word_t cmd_rdata;
logic ret;
logic host_req;
csr_word_t host_data;
logic host_ack;

// reference model and what the current command should produce
csr_word_t model_mscratch;
csr_word_t model_tohost;
csr_word_t exp_rdata;
logic chk_rdata;
csr_word_t exp_host;
logic is_tohost;
int unsigned host_delay;
logic host_seen_ack;
logic host_released;
int unsigned cycle_cnt;
int unsigned last_ack_cycle;
int unsigned value_errors = 0;
int unsigned protocol_errors = 0;
int unsigned timeout_errors = 0;

csr_unit_top #(
    .CLOCK_FREQ_HZ (4_000_000)
) csr_unit_top_i (
    .clk         (clk),
    .rst         (rst),
    .cmd_req_i   (cmd_req),
    .cmd_op_i    (cmd_op),
    .cmd_addr_i  (cmd_addr),
    .cmd_wdata_i (cmd_wdata),
    .cmd_ack_o   (cmd_ack),
    .cmd_rdata_o (cmd_rdata),
    .ret_i       (ret),
    .host_req_o  (host_req),
    .host_data_o (host_data),
    .host_ack_i  (host_ack)
);

always #50 clk = ~clk;

always @(posedge clk) begin
    if (rst) cycle_cnt <= 0;
    else cycle_cnt <= cycle_cnt + 1;
end

// ----------------------------------------------------------
// operation rule and helpers
// ----------------------------------------------------------
function automatic csr_word_t apply_op(input csr_op_t op, input csr_word_t old,
                                       input csr_word_t src);
    case (op)
        CSR_OP_RW: return src;
        CSR_OP_RS: return old | src;
        CSR_OP_RC: return old & ~src;
        default:   return old;
    endcase
endfunction

function automatic csr_op_t op_at(input int unsigned idx);
    case (idx % 3)
        0:       return CSR_OP_RW;
        1:       return CSR_OP_RS;
        default: return CSR_OP_RC;
    endcase
endfunction

task automatic print_summary();
    $display("errors: %0d value, %0d protocol, %0d timeout",
             value_errors, protocol_errors, timeout_errors);
endtask

// one four-phase command, mscratch and tohost checked against the model
task automatic run_command(input csr_op_t op, input csr_addr_t addr, input csr_word_t wdata,
                           input logic check, input csr_word_t expected,
                           output csr_word_t rdata);
    logic chk;
    csr_word_t want;
    chk = check;
    want = expected;
    if (addr == CSR_MSCRATCH) begin
        chk = 1'b1;
        want = model_mscratch;
    end else if (addr == CSR_TOHOST) begin
        chk = 1'b1;
        want = model_tohost;
    end
    @(posedge clk);
    cmd_op <= op;
    cmd_addr <= addr;
    cmd_wdata <= wdata;
    cmd_req <= 1'b1;
    chk_rdata <= chk;
    exp_rdata <= want;
    is_tohost <= (addr == CSR_TOHOST);
    exp_host <= apply_op(op, model_tohost, wdata);
    host_delay <= $urandom_range(7, 0);
    do @(posedge clk); while (!cmd_ack);
    rdata = cmd_rdata;
    last_ack_cycle = cycle_cnt;
    cmd_req <= 1'b0;
    do @(posedge clk); while (cmd_ack);
    if (addr == CSR_MSCRATCH) model_mscratch = apply_op(op, model_mscratch, wdata);
    if (addr == CSR_TOHOST) model_tohost = apply_op(op, model_tohost, wdata);
endtask

// two time reads, idle cycles in between
task automatic measure_time(input int unsigned idle, input logic poke);
    csr_word_t t0;
    csr_word_t t1;
    csr_word_t scratch;
    int unsigned c0;
    int span;
    int ticks;
    run_command(CSR_OP_RS, CSR_TIME, '0, 1'b0, '0, t0);
    c0 = last_ack_cycle;
    // a write inside the window must not move time
    if (poke) run_command(CSR_OP_RW, CSR_TIME, $urandom(), 1'b0, '0, scratch);
    repeat (idle) @(posedge clk);
    run_command(CSR_OP_RS, CSR_TIME, '0, 1'b0, '0, t1);
    span = int'(last_ack_cycle - c0);
    ticks = int'(t1 - t0);
    a_time_step: assert (ticks >= span / 4 - 1 && ticks <= span / 4 + 1) else begin
        value_errors++;
        $display("FAILED at %0t: time advanced %0d over %0d cycles", $time, ticks, span);
    end
endtask

// ----------------------------------------------------------
// host side
// ----------------------------------------------------------
always begin
    @(posedge clk);
    if (host_req && !rst) begin
        repeat (host_delay) @(posedge clk);
        host_ack <= 1'b1;
        do @(posedge clk); while (host_req);
        host_ack <= 1'b0;
    end
end

// tracks the host handshake of the command in flight
always @(posedge clk) begin
    if (rst || (!cmd_req && !cmd_ack)) begin
        host_seen_ack <= 1'b0;
        host_released <= 1'b0;
    end else if (host_req && host_ack) begin
        host_seen_ack <= 1'b1;
    end else if (host_seen_ack && !host_ack) begin
        host_released <= 1'b1;
    end
end

// ----------------------------------------------------------
// checks
// ----------------------------------------------------------
a_rdata: assert property (@(posedge clk) disable iff (rst)
    (cmd_ack && chk_rdata) |-> (cmd_rdata == exp_rdata)) else begin
    value_errors++;
    $display("FAILED at %0t: read data %h, expected %h",
             $time, $sampled(cmd_rdata), $sampled(exp_rdata));
end

a_host_data: assert property (@(posedge clk) disable iff (rst)
    host_req |-> (host_data == exp_host)) else begin
    value_errors++;
    $display("FAILED at %0t: host data %h, expected %h",
             $time, $sampled(host_data), $sampled(exp_host));
end

a_host_only_tohost: assert property (@(posedge clk) disable iff (rst)
    host_req |-> is_tohost) else begin
    protocol_errors++;
    $display("host_req_o raised for a command that does not access tohost");
end

a_ack_after_host: assert property (@(posedge clk) disable iff (rst)
    (cmd_ack && is_tohost) |-> host_released) else begin
    protocol_errors++;
    $display("cmd_ack_o rose before host_ack_i had returned low");
end

a_req_fall: assert property (@(posedge clk) disable iff (rst)
    $fell(host_req) |-> $past(host_ack)) else begin
    protocol_errors++;
    $display("host_req_o fell before host_ack_i was raised");
end

// ----------------------------------------------------------
// stimulus
// ----------------------------------------------------------
initial begin : stimulus
    csr_word_t rd;
    csr_word_t rd2;
    csr_word_t v;
    int unsigned k;
    int unsigned c_wr;
    logic pulse;
    void'($urandom(14));
    rst = 1'b1;
    cmd_req = 1'b0;
    cmd_op = CSR_OP_RW;
    cmd_addr = CSR_MSCRATCH;
    cmd_wdata = '0;
    ret = 1'b0;
    host_ack = 1'b0;
    model_mscratch = '0;
    model_tohost = '0;
    chk_rdata = 1'b0;
    exp_rdata = '0;
    exp_host = '0;
    is_tohost = 1'b0;
    host_delay = 0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;

    // mscratch rmw, each followed by a read
    for (int i = 0; i < N_RMW; i++) begin
        run_command(op_at(i), CSR_MSCRATCH, $urandom(), 1'b0, '0, rd);
        run_command(CSR_OP_RS, CSR_MSCRATCH, '0, 1'b0, '0, rd);
    end

    // minstret counts retire pulses only
    run_command(CSR_OP_RW, CSR_MINSTRET, '0, 1'b0, '0, rd);
    k = 0;
    for (int i = 0; i < RET_WINDOW; i++) begin
        @(posedge clk);
        pulse = 1'($urandom_range(1, 0));
        ret <= pulse;
        k += pulse;
    end
    @(posedge clk);
    ret <= 1'b0;
    run_command(CSR_OP_RS, CSR_MINSTRET, '0, 1'b1, k, rd);
    run_command(CSR_OP_RS, CSR_MINSTRETH, '0, 1'b1, '0, rd);

    // mcycle after a write
    v = $urandom() & 32'h3fff_ffff;
    run_command(CSR_OP_RW, CSR_MCYCLE, v, 1'b0, '0, rd);
    c_wr = last_ack_cycle;
    run_command(CSR_OP_RS, CSR_MCYCLE, '0, 1'b0, '0, rd);
    a_mcycle_range: assert (rd > v && rd <= v + (last_ack_cycle - c_wr)) else begin
        value_errors++;
        $display("FAILED at %0t: mcycle %0d after write of %0d", $time, rd, v);
    end
    run_command(CSR_OP_RS, CSR_MCYCLE, '0, 1'b0, '0, rd2);
    a_mcycle_grows: assert (rd2 > rd) else begin
        value_errors++;
        $display("FAILED at %0t: mcycle %0d not above %0d", $time, rd2, rd);
    end

    // time is read only
    measure_time(37, 1'b0);
    measure_time(61, 1'b1);

    // tohost through the host port
    for (int i = 0; i < N_HOST; i++) begin
        run_command(op_at(i), CSR_TOHOST, $urandom(), 1'b0, '0, rd);
    end
    run_command(CSR_OP_RS, CSR_TOHOST, '0, 1'b0, '0, rd);

    // unmapped address
    run_command(CSR_OP_RS, UNMAPPED, '0, 1'b1, '0, rd);
    run_command(CSR_OP_RW, UNMAPPED, $urandom(), 1'b1, '0, rd);
    run_command(CSR_OP_RS, CSR_MSCRATCH, '0, 1'b0, '0, rd);
    run_command(CSR_OP_RS, CSR_TOHOST, '0, 1'b0, '0, rd);

    repeat (2) @(posedge clk);
    print_summary();
    if (value_errors + protocol_errors + timeout_errors == 0) begin
        $display("Simulation completed successfully");
    end else begin
        $display("Simulation failed");
    end
    $finish;
end

initial begin : watchdog
    repeat (NUM_CMDS * 20 + 500) @(posedge clk);
    timeout_errors++;
    $display("watchdog expired, the tests did not finish in time");
    print_summary();
    $display("Simulation failed");
    $finish;
end

endmodule

`default_nettype wire
